// File: src/rxFifoPkg.sv
`default_nettype none

package rxFifoPkg;

  typedef logic [7:0]  rxByte_t;
  typedef logic [15:0] fifoCount_t;
  typedef logic [2:0]  regAddr_t;

  // register offsets inside one FIFO window
  localparam regAddr_t FIFO_DATA_REG       = 3'd0;
  localparam regAddr_t FIFO_STATUS_REG     = 3'd1;
  localparam regAddr_t FIFO_DATA_COUNT_MSB = 3'd2;
  localparam regAddr_t FIFO_DATA_COUNT_LSB = 3'd3;
  localparam regAddr_t FIFO_CONTROL_REG    = 3'd4;

  localparam int WB_ADR_W       = 4;
  localparam int WB_WINDOW_BIT  = 3;  // 0 selects the rx fifo

  localparam int RX_FIFO_DEPTH  = 512;
  localparam int RX_FIFO_ADDR_W = 9;
  localparam int RX_FIFO_PTR_W  = RX_FIFO_ADDR_W + 1;  // extra wrap bit

  localparam int FLUSH_BIT      = 0;  // control register

  typedef struct packed {
    regAddr_t addr;
    logic     write;
    logic     select;
    logic     strobe;
    rxByte_t  wrData;
  } busReq_t;

  // returned in status bits 2:0
  typedef struct packed {
    logic empty;
    logic full;
    logic overflow;
  } fifoStatus_t;

  localparam int STATUS_PAD_W = $bits(rxByte_t) - $bits(fifoStatus_t);

endpackage

`default_nettype wire

// File: src/wbRxDecode.sv
`timescale 1ns/1ps
`default_nettype none

module wbRxDecode
  import rxFifoPkg::*;
(
  input  wire logic                busClk,
  input  wire logic                rstSyncToBusClk,
  input  wire logic                wbCyc,
  input  wire logic                wbStb,
  input  wire logic                wbWe,
  input  wire logic [WB_ADR_W-1:0] wbAdr,
  input  wire rxByte_t             wbDatIn,
  output logic                     wbAck,
  output busReq_t                  busReq
);

  logic busCycle;

  assign busCycle = wbCyc & wbStb;

  // one wait state, every address acked
  always_ff @(posedge busClk) begin
    if (rstSyncToBusClk) begin
      wbAck <= 1'b0;
    end else begin
      wbAck <= busCycle & ~wbAck;
    end
  end

  always_comb begin
    busReq.addr   = wbAdr[2:0];
    busReq.write  = wbWe;
    busReq.select = ~wbAdr[WB_WINDOW_BIT];  // lower half of the space
    busReq.strobe = wbAck & busCycle;       // ack cycle only
    busReq.wrData = wbDatIn;
  end

  // classic handshake gives a single ack per transfer
  ackSinglePulse: assert property (
    @(posedge busClk) disable iff (rstSyncToBusClk)
    wbAck |=> !wbAck
  );

endmodule

`default_nettype wire

// File: src/rxFifoBusIf.sv
`timescale 1ns/1ps
`default_nettype none

module rxFifoBusIf
  import rxFifoPkg::*;
(
  input  wire logic        busClk,
  input  wire logic        usbClk,
  input  wire logic        rstSyncToBusClk,
  input  wire busReq_t     busReq,
  input  wire rxByte_t     fifoDataIn,
  input  wire fifoCount_t  numElementsInFifo,
  input  wire fifoStatus_t fifoStatus,
  output rxByte_t          busDataOut,
  output logic             fifoREn,
  output logic             forceEmptySyncToBusClk,
  output logic             forceEmptySyncToUsbClk
);

  logic       ctrlFlushWr;
  logic       forceEmpty;
  logic       forceEmptyReg;
  logic       forceEmptyToggle;
  logic [2:0] forceEmptyToggleSyncToUsbClk;
  rxByte_t    regData;

  assign ctrlFlushWr = busReq.strobe & busReq.select & busReq.write &
                       (busReq.addr == FIFO_CONTROL_REG) & busReq.wrData[FLUSH_BIT];

  always_ff @(posedge busClk) begin
    if (rstSyncToBusClk) begin
      forceEmpty       <= 1'b0;
      forceEmptyReg    <= 1'b0;
      forceEmptyToggle <= 1'b0;
    end else begin
      forceEmpty    <= ctrlFlushWr;
      forceEmptyReg <= forceEmpty;
      if (forceEmptySyncToBusClk) begin
        forceEmptyToggle <= ~forceEmptyToggle;  // one flip per flush
      end
    end
  end

  assign forceEmptySyncToBusClk = forceEmpty & ~forceEmptyReg;  // rising edge

  // toggle into the usb domain, edge taken from the top two stages
  always_ff @(posedge usbClk) begin
    forceEmptyToggleSyncToUsbClk <= {forceEmptyToggleSyncToUsbClk[1:0], forceEmptyToggle};
  end

  assign forceEmptySyncToUsbClk =
    forceEmptyToggleSyncToUsbClk[2] ^ forceEmptyToggleSyncToUsbClk[1];

  always_comb begin
    unique case (busReq.addr)
      FIFO_DATA_REG:       regData = fifoDataIn;
      FIFO_STATUS_REG:     regData = {{STATUS_PAD_W{1'b0}}, fifoStatus};
      FIFO_DATA_COUNT_MSB: regData = numElementsInFifo[15:8];
      FIFO_DATA_COUNT_LSB: regData = numElementsInFifo[7:0];
      default:             regData = '0;
    endcase
  end

  assign busDataOut = busReq.select ? regData : '0;  // upper window unmapped

  // pop the head byte on a data register read
  assign fifoREn = busReq.strobe & busReq.select & ~busReq.write &
                   (busReq.addr == FIFO_DATA_REG);

  popIsRead: assert property (
    @(posedge busClk) disable iff (rstSyncToBusClk)
    fifoREn |-> !busReq.write
  );

endmodule

`default_nettype wire

// File: src/rxCdcFifo.sv
`timescale 1ns/1ps
`default_nettype none

module rxCdcFifo
  import rxFifoPkg::*;
(
  input  wire logic    busClk,
  input  wire logic    usbClk,
  input  wire logic    rstSyncToBusClk,
  input  wire logic    usbWrEn,
  input  wire rxByte_t usbData,
  input  wire logic    fifoREn,
  input  wire logic    forceEmptySyncToBusClk,
  input  wire logic    forceEmptySyncToUsbClk,
  output rxByte_t      fifoDataIn,
  output fifoCount_t   numElementsInFifo,
  output fifoStatus_t  fifoStatus,
  output logic         usbFull
);

  typedef logic [RX_FIFO_PTR_W-1:0] ptr_t;

  function automatic ptr_t bin2gray(input ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic ptr_t gray2bin(input ptr_t gray);
    ptr_t bin;
    bin[RX_FIFO_PTR_W-1] = gray[RX_FIFO_PTR_W-1];
    for (int i = RX_FIFO_PTR_W - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

  rxByte_t mem [RX_FIFO_DEPTH];

  // usb domain
  logic [1:0] usbRstPipe;
  logic       usbRst;
  ptr_t       wrPtrBin;
  ptr_t       wrPtrGray;
  ptr_t       wrPtrNext;
  ptr_t       rdGraySync1;
  ptr_t       rdGraySync2;
  logic       wrAccept;
  logic       overflowUsb;

  // bus domain
  ptr_t       rdPtrBin;
  ptr_t       rdPtrGray;
  ptr_t       rdPtrNext;
  ptr_t       wrGraySync1;
  ptr_t       wrGraySync2;
  ptr_t       wrBinSync;
  ptr_t       ptrDiff;
  logic       empty;
  logic [1:0] overflowSync;

  always_ff @(posedge usbClk) begin
    usbRstPipe <= {usbRstPipe[0], rstSyncToBusClk};
  end

  assign usbRst = usbRstPipe[1];

  // full when pointers differ only in the two top gray bits
  assign usbFull = wrPtrGray == {~rdGraySync2[RX_FIFO_PTR_W-1 -: 2],
                                 rdGraySync2[RX_FIFO_PTR_W-3:0]};
  assign wrAccept  = usbWrEn & ~usbFull;
  assign wrPtrNext = wrPtrBin + ptr_t'(wrAccept);

  always_ff @(posedge usbClk) begin
    if (usbRst) begin
      wrPtrBin    <= '0;
      wrPtrGray   <= '0;
      rdGraySync1 <= '0;
      rdGraySync2 <= '0;
    end else begin
      wrPtrBin    <= wrPtrNext;
      wrPtrGray   <= bin2gray(wrPtrNext);
      rdGraySync1 <= rdPtrGray;
      rdGraySync2 <= rdGraySync1;
    end
  end

  always_ff @(posedge usbClk) begin
    if (wrAccept) begin
      mem[wrPtrBin[RX_FIFO_ADDR_W-1:0]] <= usbData;
    end
  end

  always_ff @(posedge usbClk) begin
    if (usbRst || forceEmptySyncToUsbClk) begin
      overflowUsb <= 1'b0;
    end else if (usbWrEn && usbFull) begin
      overflowUsb <= 1'b1;  // sticky until flush
    end
  end

  assign wrBinSync = gray2bin(wrGraySync2);
  assign empty     = rdPtrGray == wrGraySync2;

  always_comb begin
    if (forceEmptySyncToBusClk) begin
      rdPtrNext = wrBinSync;  // drop everything seen so far
    end else if (fifoREn && !empty) begin
      rdPtrNext = rdPtrBin + 1'b1;
    end else begin
      rdPtrNext = rdPtrBin;
    end
  end

  always_ff @(posedge busClk) begin
    if (rstSyncToBusClk) begin
      rdPtrBin     <= '0;
      rdPtrGray    <= '0;
      wrGraySync1  <= '0;
      wrGraySync2  <= '0;
      overflowSync <= '0;
    end else begin
      rdPtrBin     <= rdPtrNext;
      rdPtrGray    <= bin2gray(rdPtrNext);
      wrGraySync1  <= wrPtrGray;
      wrGraySync2  <= wrGraySync1;
      overflowSync <= {overflowSync[0], overflowUsb};
    end
  end

  assign ptrDiff           = wrBinSync - rdPtrBin;
  assign numElementsInFifo = fifoCount_t'(ptrDiff);

  // first word fall-through head
  assign fifoDataIn = empty ? '0 : mem[rdPtrBin[RX_FIFO_ADDR_W-1:0]];

  always_comb begin
    fifoStatus.empty    = empty;
    fifoStatus.full     = ptrDiff == ptr_t'(RX_FIFO_DEPTH);
    fifoStatus.overflow = overflowSync[1];
  end

  noPopWhenEmpty: assert property (
    @(posedge busClk) disable iff (rstSyncToBusClk)
    (empty && !forceEmptySyncToBusClk) |=> $stable(rdPtrBin)
  );

  noPushWhenFull: assert property (
    @(posedge usbClk) disable iff (usbRst)
    usbFull |=> $stable(wrPtrBin)
  );

endmodule

`default_nettype wire

// File: src/rxFifoSubsys.sv
`timescale 1ns/1ps
`default_nettype none

module rxFifoSubsys
  import rxFifoPkg::*;
(
  input  wire logic                busClk,
  input  wire logic                usbClk,
  input  wire logic                rstSyncToBusClk,
  input  wire logic                wbCyc,
  input  wire logic                wbStb,
  input  wire logic                wbWe,
  input  wire logic [WB_ADR_W-1:0] wbAdr,
  input  wire rxByte_t             wbDatIn,
  output rxByte_t                  wbDatOut,
  output logic                     wbAck,
  input  wire logic                usbWrEn,
  input  wire rxByte_t             usbData,
  output logic                     usbFull
);

  busReq_t     busReq;
  rxByte_t     fifoDataIn;
  fifoCount_t  numElementsInFifo;
  fifoStatus_t fifoStatus;
  logic        fifoREn;
  logic        forceEmptySyncToBusClk;
  logic        forceEmptySyncToUsbClk;

  wbRxDecode u_decode (
    .busClk          (busClk),
    .rstSyncToBusClk (rstSyncToBusClk),
    .wbCyc           (wbCyc),
    .wbStb           (wbStb),
    .wbWe            (wbWe),
    .wbAdr           (wbAdr),
    .wbDatIn         (wbDatIn),
    .wbAck           (wbAck),
    .busReq          (busReq)
  );

  rxFifoBusIf u_busIf (
    .busClk                 (busClk),
    .usbClk                 (usbClk),
    .rstSyncToBusClk        (rstSyncToBusClk),
    .busReq                 (busReq),
    .fifoDataIn             (fifoDataIn),
    .numElementsInFifo      (numElementsInFifo),
    .fifoStatus             (fifoStatus),
    .busDataOut             (wbDatOut),
    .fifoREn                (fifoREn),
    .forceEmptySyncToBusClk (forceEmptySyncToBusClk),
    .forceEmptySyncToUsbClk (forceEmptySyncToUsbClk)
  );

  rxCdcFifo u_fifo (
    .busClk                 (busClk),
    .usbClk                 (usbClk),
    .rstSyncToBusClk        (rstSyncToBusClk),
    .usbWrEn                (usbWrEn),
    .usbData                (usbData),
    .fifoREn                (fifoREn),
    .forceEmptySyncToBusClk (forceEmptySyncToBusClk),
    .forceEmptySyncToUsbClk (forceEmptySyncToUsbClk),
    .fifoDataIn             (fifoDataIn),
    .numElementsInFifo      (numElementsInFifo),
    .fifoStatus             (fifoStatus),
    .usbFull                (usbFull)
  );

endmodule

`default_nettype wire

// File: bench/tbRxFifoTasks.svh
`ifndef TB_RX_FIFO_TASKS_SVH
`define TB_RX_FIFO_TASKS_SVH

// right-shift galois form, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsrStep(input logic [31:0] state);
  logic [31:0] next;
  next = state >> 1;
  if (state[0]) begin
    next = next ^ 32'h8020_0003;
  end
  return next;
endfunction

task automatic randomByte(output rxByte_t value);
  value = '0;
  for (int i = 0; i < $bits(rxByte_t); i++) begin
    lfsrState = lfsrStep(lfsrState);  // one step per bit
    value = {value[6:0], lfsrState[0]};
  end
endtask

function automatic logic [WB_ADR_W-1:0] fifoAdr(input regAddr_t offset);
  return {1'b0, offset};  // lower window
endfunction

function automatic fifoStatus_t makeStatus(input logic empty, input logic full,
                                           input logic overflow);
  fifoStatus_t status;
  status.empty    = empty;
  status.full     = full;
  status.overflow = overflow;
  return status;
endfunction

task automatic compareByte(input string testName, input rxByte_t expected,
                           input rxByte_t actual);
  if (actual !== expected) begin
    $display("ERROR %s: expected 0x%02h actual 0x%02h", testName, expected, actual);
    mismatchCount++;
  end
endtask

task automatic compareCount(input string testName, input fifoCount_t expected,
                            input fifoCount_t actual);
  if (actual !== expected) begin
    $display("ERROR %s: expected count %0d actual %0d", testName, expected, actual);
    mismatchCount++;
  end
endtask

task automatic compareStatus(input string testName, input fifoStatus_t expected,
                             input fifoStatus_t actual);
  if (actual !== expected) begin
    $display("ERROR %s: expected status %b actual %b (empty full overflow)",
             testName, expected, actual);
    mismatchCount++;
  end
endtask

task automatic compareFlag(input string testName, input logic expected, input logic actual);
  if (actual !== expected) begin
    $display("ERROR %s: expected %b actual %b", testName, expected, actual);
    mismatchCount++;
  end
endtask

// one classic cycle, stb held through the ack cycle
task automatic busAccess(input logic write, input logic [WB_ADR_W-1:0] adr,
                         input rxByte_t wrData, output rxByte_t rdData);
  int waited;
  waited = 0;
  rdData = '0;
  @(posedge busClk);
  #1;
  wbCyc   = 1'b1;
  wbStb   = 1'b1;
  wbWe    = write;
  wbAdr   = adr;
  wbDatIn = wrData;
  do begin
    @(posedge busClk);
    #1;
    waited++;
  end while (!wbAck && waited < ACK_TIMEOUT);
  if (wbAck) begin
    rdData = wbDatOut;  // valid in the ack cycle
  end else begin
    $display("timeout: no ack for bus access at address %0d", adr);
    timeoutCount++;
  end
  @(posedge busClk);
  #1;
  compareFlag("bus ack", 1'b0, wbAck);  // ack lasts one cycle
  wbCyc = 1'b0;
  wbStb = 1'b0;
  wbWe  = 1'b0;
endtask

task automatic busRead(input logic [WB_ADR_W-1:0] adr, output rxByte_t data);
  busAccess(1'b0, adr, 8'h00, data);
endtask

task automatic busWrite(input logic [WB_ADR_W-1:0] adr, input rxByte_t data);
  rxByte_t unused;
  busAccess(1'b1, adr, data, unused);
endtask

// back-to-back usb writes of random bytes
task automatic usbWriteBytes(input int count);
  rxByte_t value;
  for (int i = 0; i < count; i++) begin
    randomByte(value);
    @(posedge usbClk);
    #1;
    usbWrEn = 1'b1;
    usbData = value;
    if (refQ.size() < RX_FIFO_DEPTH) begin
      refQ.push_back(value);  // dropped once full
    end
  end
  @(posedge usbClk);
  #1;
  usbWrEn = 1'b0;
endtask

task automatic readCount(output fifoCount_t count);
  rxByte_t msb;
  rxByte_t lsb;
  busRead(fifoAdr(FIFO_DATA_COUNT_MSB), msb);
  busRead(fifoAdr(FIFO_DATA_COUNT_LSB), lsb);
  count = {msb, lsb};
endtask

task automatic waitCount(input string testName, input fifoCount_t expected);
  fifoCount_t count;
  int polls;
  polls = 0;
  do begin
    readCount(count);
    polls++;
  end while (count !== expected && polls < POLL_TIMEOUT);
  if (count !== expected) begin
    $display("timeout: %s count did not settle at the expected value", testName);
    timeoutCount++;
    compareCount(testName, expected, count);
  end
endtask

task automatic waitStatus(input string testName, input fifoStatus_t expected);
  rxByte_t raw;
  int polls;
  polls = 0;
  do begin
    busRead(fifoAdr(FIFO_STATUS_REG), raw);
    polls++;
  end while (fifoStatus_t'(raw[2:0]) !== expected && polls < POLL_TIMEOUT);
  if (fifoStatus_t'(raw[2:0]) !== expected) begin
    $display("timeout: %s status did not settle at the expected value", testName);
    timeoutCount++;
    compareStatus(testName, expected, fifoStatus_t'(raw[2:0]));
  end else begin
    compareByte(testName, {5'b00000, expected}, raw);  // upper bits zero
  end
endtask

task automatic drainAndCheck(input string testName, input int count);
  rxByte_t data;
  for (int i = 0; i < count; i++) begin
    busRead(fifoAdr(FIFO_DATA_REG), data);
    if (refQ.size() == 0) begin
      $display("%s: more bytes read than were accepted", testName);
      mismatchCount++;
    end else begin
      compareByte(testName, refQ.pop_front(), data);
    end
  end
endtask

`endif

// File: bench/tbRxFifo.sv
`timescale 1ns/1ps
`default_nettype none

module tbRxFifo
  import rxFifoPkg::*;
();

  localparam int ACK_TIMEOUT  = 8;
  localparam int POLL_TIMEOUT = 40;

  logic                busClk;
  logic                usbClk;
  logic                rstSyncToBusClk;
  logic                wbCyc;
  logic                wbStb;
  logic                wbWe;
  logic [WB_ADR_W-1:0] wbAdr;
  rxByte_t             wbDatIn;
  rxByte_t             wbDatOut;
  logic                wbAck;
  logic                usbWrEn;
  rxByte_t             usbData;
  logic                usbFull;

  rxByte_t     refQ[$];  // accepted, not yet popped
  logic [31:0] lfsrState;
  int          mismatchCount;
  int          timeoutCount;

  rxFifoSubsys uut (
    .busClk          (busClk),
    .usbClk          (usbClk),
    .rstSyncToBusClk (rstSyncToBusClk),
    .wbCyc           (wbCyc),
    .wbStb           (wbStb),
    .wbWe            (wbWe),
    .wbAdr           (wbAdr),
    .wbDatIn         (wbDatIn),
    .wbDatOut        (wbDatOut),
    .wbAck           (wbAck),
    .usbWrEn         (usbWrEn),
    .usbData         (usbData),
    .usbFull         (usbFull)
  );

  always #2 busClk = ~busClk;
  always #3 usbClk = ~usbClk;  // unrelated to busClk

  `include "tbRxFifoTasks.svh"

  task automatic checkResetState();
    rxByte_t    data;
    fifoCount_t count;
    waitStatus("reset", makeStatus(1'b1, 1'b0, 1'b0));
    readCount(count);
    compareCount("reset", 16'd0, count);
    busRead(fifoAdr(FIFO_DATA_REG), data);
    compareByte("reset data", 8'h00, data);
  endtask

  task automatic orderAndCount();
    fifoCount_t count;
    usbWriteBytes(20);
    waitCount("order", 16'd20);
    drainAndCheck("order", 20);
    readCount(count);
    compareCount("order drained", 16'd0, count);
    waitStatus("order drained", makeStatus(1'b1, 1'b0, 1'b0));
  endtask

  task automatic wideCount();
    rxByte_t data;
    usbWriteBytes(300);
    waitCount("wide", 16'd300);
    busRead(fifoAdr(FIFO_DATA_COUNT_MSB), data);
    compareByte("wide msb", 8'd1, data);  // 300 = 256 + 44
    busRead(fifoAdr(FIFO_DATA_COUNT_LSB), data);
    compareByte("wide lsb", 8'd44, data);
    drainAndCheck("wide", 300);
    waitCount("wide drained", 16'd0);
  endtask

  task automatic fullAndOverflow();
    usbWriteBytes(515);
    @(posedge usbClk);
    #1;
    compareFlag("full usbFull", 1'b1, usbFull);
    waitStatus("full", makeStatus(1'b0, 1'b1, 1'b1));
    waitCount("full", fifoCount_t'(RX_FIFO_DEPTH));
    drainAndCheck("full", RX_FIFO_DEPTH);
    waitStatus("full drained", makeStatus(1'b1, 1'b0, 1'b1));  // overflow sticks
  endtask

  task automatic flushFifo();
    rxByte_t    data;
    fifoCount_t count;
    usbWriteBytes(10);
    waitCount("flush", 16'd10);
    busWrite(fifoAdr(FIFO_CONTROL_REG), 8'h00);  // bit 0 clear
    readCount(count);
    compareCount("flush bit clear", 16'd10, count);
    waitStatus("flush bit clear", makeStatus(1'b0, 1'b0, 1'b1));
    busWrite(fifoAdr(FIFO_CONTROL_REG), 8'h01);
    refQ.delete();
    waitCount("flush", 16'd0);
    waitStatus("flush", makeStatus(1'b1, 1'b0, 1'b0));
    busRead(fifoAdr(FIFO_DATA_REG), data);
    compareByte("flush data", 8'h00, data);
  endtask

  task automatic unmappedAccess();
    rxByte_t    data;
    fifoCount_t count;
    usbWriteBytes(3);
    waitCount("unmapped", 16'd3);
    for (int adr = 5; adr < 2 ** WB_ADR_W; adr++) begin
      busRead(adr[WB_ADR_W-1:0], data);
      compareByte("unmapped read", 8'h00, data);
    end
    busWrite({1'b1, FIFO_CONTROL_REG}, 8'h01);  // upper window, no flush
    readCount(count);
    compareCount("unmapped", 16'd3, count);
    drainAndCheck("unmapped", 3);
  endtask

  initial begin
    busClk          = 1'b0;
    usbClk          = 1'b0;
    rstSyncToBusClk = 1'b1;
    wbCyc           = 1'b0;
    wbStb           = 1'b0;
    wbWe            = 1'b0;
    wbAdr           = '0;
    wbDatIn         = '0;
    usbWrEn         = 1'b0;
    usbData         = '0;
    lfsrState       = 32'h3077_e032;
    mismatchCount   = 0;
    timeoutCount    = 0;
    repeat (3) @(posedge busClk);
    #1;
    rstSyncToBusClk = 1'b0;

    checkResetState();
    orderAndCount();
    wideCount();
    fullAndOverflow();
    flushFifo();
    unmappedAccess();

    $display("errors: %0d mismatches, %0d timeouts", mismatchCount, timeoutCount);
    if (mismatchCount == 0 && timeoutCount == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+bench
src/rxFifoPkg.sv
src/wbRxDecode.sv
src/rxFifoBusIf.sv
src/rxCdcFifo.sv
src/rxFifoSubsys.sv
bench/tbRxFifo.sv
